// ==== hw/lcd_pkg.sv ====
package lcd_pkg;

	// upper half of a control byte, lower half is always 4'b1111
	localparam logic [3:0] ctrl_command = 4'b0001;
	localparam logic [3:0] ctrl_data    = 4'b0101;
	localparam logic [3:0] ctrl_read    = 4'b0011;

	// position of the busy flag in the status byte
	localparam int busy_bit = 7;

	localparam int init_num_commands = 22;

	// milliseconds to clock cycles
	function automatic int unsigned cycles_per_ms(input int unsigned clk_hz,
		input int unsigned ms);
		return clk_hz / 1000 * ms;
	endfunction

	// microseconds to clock cycles, kept exact for slow simulation clocks
	function automatic int unsigned cycles_per_us(input int unsigned clk_hz,
		input int unsigned us);
		return clk_hz / 1000 * us / 1000;
	endfunction

	// per command: control nibble, low data nibble, high data nibble
	localparam logic [0:init_num_commands*3-1][3:0] init_table = {
		ctrl_command, 4'b1011, 4'b0011, ctrl_command, 4'b0010, 4'b0000,
		ctrl_command, 4'b0110, 4'b0000, ctrl_command, 4'b1001, 4'b0000,
		ctrl_command, 4'b0000, 4'b0001, ctrl_command, 4'b0000, 4'b1100,
		ctrl_command, 4'b0010, 4'b0111, ctrl_data,    4'b0000, 4'b0000,
		ctrl_command, 4'b0110, 4'b0111, ctrl_data,    4'b0010, 4'b0000,
		// extended set, bias and scroll
		ctrl_command, 4'b1010, 4'b0011, ctrl_command, 4'b0010, 4'b0001,
		// contrast, follower, oscillator
		ctrl_command, 4'b1001, 4'b0011, ctrl_command, 4'b1011, 4'b0001,
		ctrl_command, 4'b0111, 4'b0101, ctrl_command, 4'b0000, 4'b0111,
		ctrl_command, 4'b1110, 4'b0110,
		// back to base set, display on, clear, home
		ctrl_command, 4'b1000, 4'b0011, ctrl_command, 4'b0110, 4'b0000,
		ctrl_command, 4'b1100, 4'b0000, ctrl_command, 4'b0001, 4'b0000,
		ctrl_command, 4'b0010, 4'b0000
	};

endpackage

// ==== hw/bus_pkg.sv ====
package bus_pkg;

	// ------------------------------------------------------------------------
	// controller side of the serial bus
	// ------------------------------------------------------------------------

	// byte to transfer, held while enable is high
	typedef struct packed {
		logic       enable;
		logic [7:0] data;
	} bus_req_t;

	// master status plus last received byte
	typedef struct packed {
		logic       ready;
		logic       next;
		logic [7:0] rx_data;
	} bus_resp_t;

endpackage

// ==== hw/char_buffer.sv ====
module char_buffer #(
	parameter int LCD_SIZE         = 4*20,
	parameter int LCD_NUM_ADDRBITS = 7
) (
	input  logic                        in_clk,
	input  logic                        wr_en,
	input  logic [LCD_NUM_ADDRBITS-1:0] wr_addr,
	input  logic [7:0]                  wr_char,
	input  logic [LCD_NUM_ADDRBITS-1:0] rd_addr,
	output logic [7:0]                  rd_char
);

	// one byte per display cell
	logic [7:0] mem [LCD_SIZE];

	logic wr_in_range;
	logic rd_in_range;

	// address space may be larger than the display
	assign wr_in_range = (int'(wr_addr) < LCD_SIZE);
	assign rd_in_range = (int'(rd_addr) < LCD_SIZE);

	// host port
	always_ff @(posedge in_clk) begin
		if (wr_en && wr_in_range) begin
			mem[wr_addr] <= wr_char;
		end
	end

	// controller port, read in the same cycle
	// out of range reads give a blank
	always_comb begin
		if (rd_in_range) begin
			rd_char = mem[rd_addr];
		end else begin
			rd_char = 8'h20;
		end
	end

endmodule

// ==== hw/serial_bus_master.sv ====
module serial_bus_master #(
	parameter int SCLK_DIV = 8
) (
	input  logic                in_clk,
	input  logic                in_rst,
	input  bus_pkg::bus_req_t   req,
	input  logic                sdi,
	output bus_pkg::bus_resp_t  resp,
	output logic                cs_n,
	output logic                sclk,
	output logic                sdo
);

	localparam int DIV_W = $clog2(SCLK_DIV) + 1;

	// control
	logic             shifting;
	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	logic             next_q;
	logic             ready_q;

	// payload
	logic [7:0] tx_shift;
	logic [7:0] rx_shift;
	logic [7:0] rx_data;
	logic [7:0] rx_next;

	logic tick;
	logic fall;
	logic rise;
	logic byte_end;
	logic load;

	// half period of sclk elapsed
	assign tick = shifting && (div_cnt == DIV_W'(SCLK_DIV - 1));
	assign fall = tick && sclk;
	assign rise = tick && !sclk;

	// last rising edge of bit 7
	assign byte_end = rise && (bit_cnt == 3'd7);

	// new byte taken when idle or right at a byte boundary
	assign load = req.enable && (!shifting || byte_end);

	// lsb arrives first, so shift in from the top
	assign rx_next = {sdi, rx_shift[7:1]};

	// ------------------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			shifting <= 1'b0;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			cs_n     <= 1'b1;
			sclk     <= 1'b1;
			sdo      <= 1'b1;
			next_q   <= 1'b0;
			ready_q  <= 1'b1;
		end else begin
			// one cycle strobe per latched byte
			next_q <= load;

			if (tick) begin
				div_cnt <= '0;
				sclk    <= !sclk;
			end else if (shifting) begin
				div_cnt <= div_cnt + 1'b1;
			end

			// data changes on the falling edge
			if (fall) begin
				sdo <= tx_shift[0];
			end
			if (rise) begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			if (load) begin
				shifting <= 1'b1;
				div_cnt  <= '0;
				bit_cnt  <= '0;
				cs_n     <= 1'b0;
				ready_q  <= 1'b0;
			end else if (byte_end) begin
				// nothing pending, release the bus
				shifting <= 1'b0;
				cs_n     <= 1'b1;
				ready_q  <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// shift registers
	// ------------------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (load) begin
			tx_shift <= req.data;
		end else if (fall) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end

		// sample on the rising edge
		if (rise) begin
			rx_shift <= rx_next;
		end
		if (byte_end) begin
			rx_data <= rx_next;
		end
	end

	assign resp.ready   = ready_q;
	assign resp.next    = next_q;
	assign resp.rx_data = rx_data;

endmodule

// ==== hw/lcd_3wire.sv ====
module lcd_3wire #(
	parameter int MAIN_CLK         = 50_000_000,
	parameter int LCD_SIZE         = 4*20,
	parameter int LCD_NUM_ADDRBITS = 7,
	parameter bit READ_BUSY_FLAG   = 1'b1
) (
	input  logic                        in_clk,
	input  logic                        in_rst,
	input  logic                        update,
	input  bus_pkg::bus_resp_t          bus_resp,
	input  logic [7:0]                  mem_word,
	output logic                        lcd_reset_n,
	output bus_pkg::bus_req_t           bus_req,
	output logic [LCD_NUM_ADDRBITS-1:0] mem_addr,
	output logic [7:0]                  busy_flag
);

	import lcd_pkg::*;

	// delays in clock cycles
	localparam int WAIT_PRERESET = cycles_per_ms(MAIN_CLK, 50);
	localparam int WAIT_RESET    = cycles_per_us(MAIN_CLK, 500);
	localparam int WAIT_RESETTED = cycles_per_ms(MAIN_CLK, 1);
	localparam int WAIT_INIT     = cycles_per_us(MAIN_CLK, 100);
	localparam int WAIT_UPDATE   = cycles_per_ms(MAIN_CLK, 100);

	// longest delay sets the timer width
	localparam int WAIT_W = $clog2(WAIT_UPDATE + 1) + 1;
	localparam int INIT_W = $clog2(init_num_commands) + 1;
	localparam int WR_W   = $clog2(LCD_SIZE) + 1;

	typedef enum logic [4:0] {
		s_wait_prereset, s_reset, s_post_reset,
		s_init_seq, s_pace,
		s_poll_cmd, s_poll_dummy, s_poll_wait, s_poll_check,
		s_wait_update, s_idle,
		s_home_ctrl, s_home_lo, s_home_hi, s_home_wait,
		s_data_ctrl, s_data
	} state_t;

	state_t state, state_nxt;
	// where to go once pacing is over
	state_t after_pace, after_pace_nxt;

	logic [WAIT_W-1:0] wait_cnt;
	logic [WAIT_W-1:0] wait_max;
	logic              wait_done;

	logic [INIT_W-1:0] init_cycle, init_cycle_nxt;
	logic [1:0]        byte_cycle, byte_cycle_nxt;
	logic [WR_W-1:0]   write_cycle, write_cycle_nxt;
	logic [6:0]        init_idx;
	logic [7:0]        busy_flag_nxt;

	logic next_last;
	logic next_edge;

	// rising edge of next, one per latched byte
	assign next_edge = bus_resp.next && !next_last;
	assign wait_done = (wait_cnt == wait_max);
	assign init_idx  = 7'(init_cycle) * 7'd3 + 7'(byte_cycle);

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state       <= s_wait_prereset;
			after_pace  <= s_wait_prereset;
			wait_cnt    <= '0;
			init_cycle  <= '0;
			byte_cycle  <= '0;
			write_cycle <= '0;
			next_last   <= 1'b0;
			busy_flag   <= '0;
		end else begin
			state       <= state_nxt;
			after_pace  <= after_pace_nxt;
			// timer restarts whenever it hits the limit of the current state
			if (wait_done) begin
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
			init_cycle  <= init_cycle_nxt;
			byte_cycle  <= byte_cycle_nxt;
			write_cycle <= write_cycle_nxt;
			next_last   <= bus_resp.next;
			busy_flag   <= busy_flag_nxt;
		end
	end

	// timer limit depends on the state only
	always_comb begin
		case (state)
			s_wait_prereset: wait_max = WAIT_W'(WAIT_PRERESET);
			s_reset:         wait_max = WAIT_W'(WAIT_RESET);
			s_post_reset:    wait_max = WAIT_W'(WAIT_RESETTED);
			s_pace:          wait_max = READ_BUSY_FLAG ? '0 : WAIT_W'(WAIT_INIT);
			s_home_wait:     wait_max = WAIT_W'(WAIT_INIT);
			s_wait_update:   wait_max = WAIT_W'(WAIT_UPDATE);
			default:         wait_max = '0;
		endcase
	end

	always_comb begin
		state_nxt       = state;
		after_pace_nxt  = after_pace;
		init_cycle_nxt  = init_cycle;
		byte_cycle_nxt  = byte_cycle;
		write_cycle_nxt = write_cycle;
		busy_flag_nxt   = busy_flag;
		lcd_reset_n     = 1'b1;
		mem_addr        = '0;
		bus_req         = '0;

		case (state)
			// ----------------------------------------------------------------
			// reset window
			// ----------------------------------------------------------------
			s_wait_prereset: if (wait_done) state_nxt = s_reset;
			s_reset: begin
				lcd_reset_n   = 1'b0;
				busy_flag_nxt = '1;
				if (wait_done) state_nxt = s_post_reset;
			end
			s_post_reset: if (wait_done) state_nxt = s_init_seq;

			// ----------------------------------------------------------------
			// init commands, three bytes each
			// ----------------------------------------------------------------
			s_init_seq: begin
				if (next_edge) byte_cycle_nxt = byte_cycle + 1'b1;
				if (byte_cycle == 2'd3) begin
					state_nxt      = s_pace;
					after_pace_nxt = s_init_seq;
					init_cycle_nxt = init_cycle + 1'b1;
					byte_cycle_nxt = '0;
				end else if (init_cycle == INIT_W'(init_num_commands)) begin
					// all sent, let the last byte drain
					if (bus_resp.ready) begin
						state_nxt      = s_wait_update;
						init_cycle_nxt = '0;
					end
				end else begin
					bus_req.enable = 1'b1;
					if (byte_cycle == 2'd0) begin
						bus_req.data = {init_table[init_idx], 4'b1111};
					end else begin
						bus_req.data = {4'b0000, init_table[init_idx]};
					end
				end
			end

			// busy poll or fixed delay
			s_pace: begin
				if (READ_BUSY_FLAG) state_nxt = s_poll_cmd;
				else if (wait_done) state_nxt = after_pace;
			end

			// ----------------------------------------------------------------
			// busy flag poll
			// ----------------------------------------------------------------
			s_poll_cmd: begin
				bus_req.enable = 1'b1;
				bus_req.data   = {ctrl_read, 4'b1111};
				if (next_edge) state_nxt = s_poll_dummy;
			end
			s_poll_dummy: begin
				// status comes back during this byte
				bus_req.enable = 1'b1;
				if (next_edge) state_nxt = s_poll_wait;
			end
			s_poll_wait: begin
				if (bus_resp.ready) begin
					busy_flag_nxt = bus_resp.rx_data;
					state_nxt     = s_poll_check;
				end
			end
			s_poll_check: begin
				if (busy_flag[busy_bit]) state_nxt = s_poll_cmd;
				else state_nxt = after_pace;
			end

			// ----------------------------------------------------------------
			// display refresh
			// ----------------------------------------------------------------
			s_wait_update: if (wait_done) state_nxt = s_idle;
			s_idle: begin
				if (update) begin
					state_nxt      = s_pace;
					after_pace_nxt = s_home_ctrl;
				end
			end
			s_home_ctrl: begin
				bus_req.enable = 1'b1;
				bus_req.data   = {ctrl_command, 4'b1111};
				if (next_edge) state_nxt = s_home_lo;
			end
			// return home is 8'h02, low nibble first
			s_home_lo: begin
				bus_req.enable = 1'b1;
				bus_req.data   = 8'h02;
				if (next_edge) state_nxt = s_home_hi;
			end
			s_home_hi: begin
				bus_req.enable = 1'b1;
				bus_req.data   = 8'h00;
				if (next_edge) state_nxt = s_home_wait;
			end
			s_home_wait: if (wait_done) state_nxt = s_data_ctrl;
			s_data_ctrl: begin
				bus_req.enable = 1'b1;
				bus_req.data   = {ctrl_data, 4'b1111};
				if (next_edge) begin
					state_nxt       = s_data;
					write_cycle_nxt = '0;
					byte_cycle_nxt  = '0;
				end
			end
			s_data: begin
				if (next_edge) byte_cycle_nxt = byte_cycle + 1'b1;
				if (byte_cycle == 2'd2) begin
					write_cycle_nxt = write_cycle + 1'b1;
					byte_cycle_nxt  = '0;
				end else if (write_cycle == WR_W'(LCD_SIZE)) begin
					if (bus_resp.ready) begin
						state_nxt       = s_idle;
						write_cycle_nxt = '0;
					end
				end else begin
					mem_addr       = LCD_NUM_ADDRBITS'(write_cycle);
					bus_req.enable = 1'b1;
					// low nibble, then high nibble
					bus_req.data   = {4'b0000, byte_cycle[0] ? mem_word[7:4] : mem_word[3:0]};
				end
			end
			default: state_nxt = s_wait_prereset;
		endcase
	end

endmodule

// ==== hw/lcd_display_top.sv ====
module lcd_display_top #(
	parameter int MAIN_CLK         = 50_000_000,
	parameter int SCLK_DIV         = 8,
	parameter int LCD_SIZE         = 4*20,
	parameter int LCD_NUM_ADDRBITS = 7,
	parameter bit READ_BUSY_FLAG   = 1'b1
) (
	input  logic                        in_clk,
	input  logic                        in_rst,
	input  logic                        update,
	input  logic                        wr_en,
	input  logic [LCD_NUM_ADDRBITS-1:0] wr_addr,
	input  logic [7:0]                  wr_char,
	input  logic                        sdi,
	output logic                        lcd_reset_n,
	output logic                        cs_n,
	output logic                        sclk,
	output logic                        sdo,
	output logic [7:0]                  busy_flag
);

	import bus_pkg::*;

	bus_req_t                    bus_req;
	bus_resp_t                   bus_resp;
	logic [LCD_NUM_ADDRBITS-1:0] mem_addr;
	logic [7:0]                  mem_word;

	// host writes, controller reads
	char_buffer #(
		.LCD_SIZE(LCD_SIZE), .LCD_NUM_ADDRBITS(LCD_NUM_ADDRBITS)
	) u_buffer (
		.in_clk(in_clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_char(wr_char),
		.rd_addr(mem_addr), .rd_char(mem_word)
	);

	lcd_3wire #(
		.MAIN_CLK(MAIN_CLK), .LCD_SIZE(LCD_SIZE),
		.LCD_NUM_ADDRBITS(LCD_NUM_ADDRBITS), .READ_BUSY_FLAG(READ_BUSY_FLAG)
	) u_ctrl (
		.in_clk(in_clk), .in_rst(in_rst), .update(update), .bus_resp(bus_resp),
		.mem_word(mem_word), .lcd_reset_n(lcd_reset_n), .bus_req(bus_req),
		.mem_addr(mem_addr), .busy_flag(busy_flag)
	);

	// byte-wide serial link to the display
	serial_bus_master #(
		.SCLK_DIV(SCLK_DIV)
	) u_bus (
		.in_clk(in_clk), .in_rst(in_rst), .req(bus_req), .sdi(sdi),
		.resp(bus_resp), .cs_n(cs_n), .sclk(sclk), .sdo(sdo)
	);

endmodule

// ==== tests/lcd_display_checker.sv ====
module lcd_display_checker #(
	parameter int LCD_SIZE = 4*20
) (
	input  logic                  in_clk,
	input  logic                  in_rst,
	input  logic                  cs_n,
	input  logic                  sclk,
	input  logic                  sdo,
	input  logic                  sdi,
	input  logic                  lcd_reset_n,
	input  logic [7:0]            busy_flag,
	input  logic [LCD_SIZE*8-1:0] exp_chars,
	input  int                    exp_busy,
	output int                    refreshes_started,
	output int                    refreshes_done,
	output int                    tests_run,
	output int                    tests_failed,
	output int                    errors
);

	timeunit 1ns;
	timeprecision 100ps;

	import lcd_pkg::*;

	// one expected bus byte, flagged when it closes a busy poll
	typedef struct packed {
		logic       last_poll;
		logic [7:0] value;
	} exp_byte_t;

	exp_byte_t exp_q[$];

	logic       rst_q;
	logic       sclk_q;
	logic       cs_n_q;
	logic       reset_n_q;
	logic [7:0] tx_shift;
	logic [7:0] rx_shift;
	int         bit_cnt;
	int         byte_idx;
	int         total_bytes;
	int         reset_lows;
	int         test_errors;
	string      test_name;
	logic       in_init;
	// status byte the controller should show once a poll is over
	logic       flag_pending;
	logic [7:0] flag_exp;

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		byte_idx    = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors > 0) begin
			tests_failed++;
			$display("test %s: fail, %0d errors", test_name, test_errors);
		end else begin
			$display("test %s: pass, %0d bytes", test_name, byte_idx);
		end
	endtask

	// read control byte plus dummy byte, once per busy answer and once more
	task automatic push_poll(input int busy_count);
		int   i;
		logic last;
		for (i = 0; i <= busy_count; i++) begin
			last = (i == busy_count);
			exp_q.push_back({1'b0, ctrl_read, 4'b1111});
			exp_q.push_back({last, 8'h00});
		end
	endtask

	// ------------------------------------------------------------------------
	// expected streams
	// ------------------------------------------------------------------------
	task automatic build_init();
		int c;
		for (c = 0; c < init_num_commands; c++) begin
			exp_q.push_back({1'b0, init_table[3*c], 4'b1111});
			exp_q.push_back({1'b0, 4'b0000, init_table[3*c+1]});
			exp_q.push_back({1'b0, 4'b0000, init_table[3*c+2]});
			push_poll(exp_busy);
		end
	endtask

	task automatic build_refresh();
		int         i;
		logic [7:0] ch;
		push_poll(exp_busy);
		// return home, low nibble first
		exp_q.push_back({1'b0, ctrl_command, 4'b1111});
		exp_q.push_back({1'b0, 8'h02});
		exp_q.push_back({1'b0, 8'h00});
		exp_q.push_back({1'b0, ctrl_data, 4'b1111});
		for (i = 0; i < LCD_SIZE; i++) begin
			ch = exp_chars[i*8 +: 8];
			exp_q.push_back({1'b0, 4'b0000, ch[3:0]});
			exp_q.push_back({1'b0, 4'b0000, ch[7:4]});
		end
	endtask

	task automatic handle_byte(input logic [7:0] tx, input logic [7:0] rx);
		exp_byte_t e;
		if (total_bytes == 0) begin
			// first byte closes the reset window
			if (reset_lows != 1) begin
				report_error($sformatf("lcd_reset_n went low %0d times before the first byte",
					reset_lows));
			end
			end_test();
			start_test("init");
			in_init = 1'b1;
			build_init();
		end else if (exp_q.size() == 0) begin
			// traffic after idle is a refresh
			refreshes_started++;
			start_test($sformatf("refresh %0d", refreshes_started));
			build_refresh();
		end
		total_bytes++;

		if (flag_pending && busy_flag !== flag_exp) begin
			report_error($sformatf("busy_flag is %h, expected %h", busy_flag, flag_exp));
		end
		flag_pending = 1'b0;

		e = exp_q.pop_front();
		if (tx !== e.value) begin
			report_error($sformatf("%s byte %0d is %h, expected %h", test_name, byte_idx,
				tx, e.value));
		end
		if (e.last_poll) begin
			flag_pending = 1'b1;
			flag_exp     = rx;
		end
		byte_idx++;

		if (exp_q.size() == 0) begin
			end_test();
			if (!in_init) refreshes_done++;
			in_init = 1'b0;
		end
	endtask

	// ------------------------------------------------------------------------
	// pin sampling, mid cycle where all DUT outputs are settled
	// ------------------------------------------------------------------------
	always @(negedge in_clk) begin
		if (in_rst) begin
			rst_q             = 1'b1;
			sclk_q            = 1'b1;
			cs_n_q            = 1'b1;
			reset_n_q         = 1'b1;
			bit_cnt           = 0;
			total_bytes       = 0;
			reset_lows        = 0;
			flag_pending      = 1'b0;
			in_init           = 1'b0;
			refreshes_started = 0;
			refreshes_done    = 0;
			tests_run         = 0;
			tests_failed      = 0;
			errors            = 0;
			exp_q.delete();
		end else begin
			// idle levels right after reset
			if (rst_q) begin
				start_test("reset");
				if (cs_n !== 1'b1 || sclk !== 1'b1 || lcd_reset_n !== 1'b1) begin
					report_error("bus or lcd_reset_n not idle after reset");
				end
			end
			rst_q = 1'b0;

			if (reset_n_q && !lcd_reset_n) begin
				reset_lows++;
				if (total_bytes > 0) report_error("lcd_reset_n went low after bus traffic");
			end

			// rising sclk, both lines sampled lsb first
			if (sclk && !sclk_q) begin
				if (cs_n_q) report_error("serial clock rose while chip select was high");
				tx_shift = {sdo, tx_shift[7:1]};
				rx_shift = {sdi, rx_shift[7:1]};
				bit_cnt++;
				if (bit_cnt == 8) begin
					handle_byte(tx_shift, rx_shift);
					bit_cnt = 0;
				end
			end

			sclk_q    = sclk;
			cs_n_q    = cs_n;
			reset_n_q = lcd_reset_n;
		end
	end

endmodule

// ==== tests/lcd_display_tb.sv ====
module lcd_display_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import lcd_pkg::*;

	localparam int MAIN_CLK         = 100_000;
	localparam int SCLK_DIV         = 8;
	localparam int LCD_SIZE         = 4*20;
	localparam int LCD_NUM_ADDRBITS = 7;
	localparam int CLK_PERIOD       = 40;
	localparam int NUM_ROWS         = 4;

	// ------------------------------------------------------------------------
	// run length for the watchdog
	// ------------------------------------------------------------------------
	localparam int BYTE_CYCLES    = 16 * SCLK_DIV;
	// 50 ms, 0.5 ms and 1 ms before init, 100 ms after it
	localparam int STARTUP_CYCLES = MAIN_CLK / 1000 * 151 + MAIN_CLK / 2000;
	// init commands with up to four polls each
	localparam int INIT_BYTES     = 3 * init_num_commands + 8 * init_num_commands;
	localparam int ROW_BYTES      = 2 * LCD_SIZE + 8;
	localparam int WATCHDOG_CYCLES =
		(STARTUP_CYCLES + (INIT_BYTES + NUM_ROWS * ROW_BYTES) * BYTE_CYCLES) * 2;

	// one line of the stimulus table
	typedef struct packed {
		logic [3:0]  busy_count;
		logic [31:0] fill_seed;
		logic [7:0]  num_writes;
	} test_row_t;

	test_row_t rows [NUM_ROWS];

	logic                        in_clk;
	logic                        in_rst;
	logic                        update;
	logic                        wr_en;
	logic [LCD_NUM_ADDRBITS-1:0] wr_addr;
	logic [7:0]                  wr_char;
	logic                        sdi;
	logic                        lcd_reset_n;
	logic                        cs_n;
	logic                        sclk;
	logic                        sdo;
	logic [7:0]                  busy_flag;

	// expected display contents
	logic [LCD_SIZE*8-1:0] shadow;
	int                    cur_busy;
	integer                seed;

	int refreshes_started;
	int refreshes_done;
	int tests_run;
	int tests_failed;
	int errors;

	// LCD model state
	logic       m_sclk_q;
	logic [7:0] m_shift;
	logic [7:0] m_last;
	logic [7:0] status;
	logic       answering;
	logic       in_poll;
	int         m_bits;
	int         busy_left;
	int         poll_idx;

	lcd_display_top #(
		.MAIN_CLK(MAIN_CLK), .SCLK_DIV(SCLK_DIV), .LCD_SIZE(LCD_SIZE),
		.LCD_NUM_ADDRBITS(LCD_NUM_ADDRBITS)
	) u_dut (
		.in_clk(in_clk), .in_rst(in_rst), .update(update), .wr_en(wr_en),
		.wr_addr(wr_addr), .wr_char(wr_char), .sdi(sdi), .lcd_reset_n(lcd_reset_n),
		.cs_n(cs_n), .sclk(sclk), .sdo(sdo), .busy_flag(busy_flag)
	);

	lcd_display_checker #(
		.LCD_SIZE(LCD_SIZE)
	) u_checker (
		.in_clk(in_clk), .in_rst(in_rst), .cs_n(cs_n), .sclk(sclk), .sdo(sdo),
		.sdi(sdi), .lcd_reset_n(lcd_reset_n), .busy_flag(busy_flag),
		.exp_chars(shadow), .exp_busy(cur_busy),
		.refreshes_started(refreshes_started), .refreshes_done(refreshes_done),
		.tests_run(tests_run), .tests_failed(tests_failed), .errors(errors)
	);

	initial begin
		in_clk = 1'b0;
		forever #(CLK_PERIOD/2) in_clk = ~in_clk;
	end

	// ------------------------------------------------------------------------
	// LCD model answers the byte after a read control byte
	// ------------------------------------------------------------------------
	always @(negedge in_clk) begin
		if (in_rst) begin
			sdi      <= 1'b0;
			m_sclk_q  = 1'b1;
			m_bits    = 0;
			m_last    = 8'h00;
			answering = 1'b0;
			in_poll   = 1'b0;
		end else begin
			// next bit goes out on sdi at falling sclk
			if (!sclk && m_sclk_q) begin
				if (m_bits == 0) begin
					answering = (m_last == {ctrl_read, 4'b1111});
					if (answering) begin
						// new poll sequence takes the count of the current row
						if (!in_poll) begin
							busy_left = cur_busy;
							poll_idx  = 0;
							in_poll   = 1'b1;
						end
						poll_idx++;
						status[7]   = (busy_left > 0);
						status[6:0] = 7'(poll_idx);
						if (busy_left > 0) busy_left--;
						else in_poll = 1'b0;
					end
				end
				sdi <= answering ? status[m_bits] : 1'b0;
			end
			if (sclk && !m_sclk_q) begin
				m_shift = {sdo, m_shift[7:1]};
				m_bits++;
				if (m_bits == 8) begin
					m_last = m_shift;
					m_bits = 0;
				end
			end
			m_sclk_q = sclk;
		end
	end

	task automatic write_char(input int addr, input logic [7:0] ch);
		@(negedge in_clk);
		wr_en   <= 1'b1;
		wr_addr <= LCD_NUM_ADDRBITS'(addr);
		wr_char <= ch;
		@(negedge in_clk);
		wr_en   <= 1'b0;
	endtask

	// full rows cover every cell and short rows hit random cells
	task automatic fill_buffer(input int r);
		int         i;
		int         addr;
		logic [7:0] ch;
		seed = 32'h1533 ^ rows[r].fill_seed;
		for (i = 0; i < rows[r].num_writes; i++) begin
			if (rows[r].num_writes == LCD_SIZE) addr = i;
			else addr = {$random(seed)} % LCD_SIZE;
			ch = 8'($random(seed));
			write_char(addr, ch);
			shadow[addr*8 +: 8] = ch;
		end
		// write past the display must leave the refresh unchanged
		if (rows[r].num_writes < LCD_SIZE) begin
			ch = 8'($random(seed));
			write_char(LCD_SIZE + 20 + r, ch);
		end
	endtask

	task automatic request_refresh(input int r);
		@(negedge in_clk);
		update <= 1'b1;
		// update only counts in idle so it stays high until the refresh shows up
		wait (refreshes_started == r + 1);
		@(negedge in_clk);
		update <= 1'b0;
		wait (refreshes_done == r + 1);
	endtask

	initial begin
		int r;
		in_rst   = 1'b1;
		update   = 1'b0;
		wr_en    = 1'b0;
		wr_addr  = '0;
		wr_char  = '0;
		sdi      = 1'b0;
		shadow   = '0;
		// busy answers, fill seed, writes
		rows[0]  = {4'd1, 32'h0000_0000, 8'd80};
		rows[1]  = {4'd0, 32'h0000_00a5, 8'd6};
		rows[2]  = {4'd3, 32'h0000_5a00, 8'd1};
		rows[3]  = {4'd2, 32'h0001_0000, 8'd0};
		cur_busy = rows[0].busy_count;

		repeat (10) @(posedge in_clk);
		@(negedge in_clk);
		in_rst <= 1'b0;

		for (r = 0; r < NUM_ROWS; r++) begin
			cur_busy <= rows[r].busy_count;
			fill_buffer(r);
			request_refresh(r);
		end

		@(negedge in_clk);
		$display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && tests_run == NUM_ROWS + 2) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// whole run bounded
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
hw/lcd_pkg.sv
hw/bus_pkg.sv
hw/char_buffer.sv
hw/serial_bus_master.sv
hw/lcd_3wire.sv
hw/lcd_display_top.sv
tests/lcd_display_checker.sv
tests/lcd_display_tb.sv
